/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_fetch_stage
FILELIST  = verilog.f

SIM  = obj_dir/V$(TOP)
SRCS = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Fails unless the pass line shows up in the simulator output
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "RESULT: PASS"

clean:
	rm -rf obj_dir

/* design/fetch_fsm.sv */
module fetch_fsm (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                hit_i,
    input  fetch_pkg::word_t    rd_word_i,
    input  logic                out_ready_i,
    input  logic                mem_ready_i,
    input  logic                refill_valid_i,
    input  logic                resolve_valid_i,
    input  logic                resolve_taken_i,
    output logic                issue_o,
    output logic                refill_we_o,
    output logic                redirect_o,
    output logic                out_valid_o,
    output logic                mem_req_o
);

    fetch_pkg::fetch_state_e state_q;
    fetch_pkg::fetch_state_e state_d;
    logic                    out_valid_q;
    logic                    out_free;
    logic                    is_ctrl_flow;
    logic [6:0]              opcode;

    assign opcode = rd_word_i[6:0];

    assign is_ctrl_flow = (opcode == fetch_pkg::OPCODE_BRANCH) ||
                          (opcode == fetch_pkg::OPCODE_JAL) ||
                          (opcode == fetch_pkg::OPCODE_JALR);

    // Output register empty or draining this cycle
    assign out_free = !out_valid_q || out_ready_i;

    assign issue_o     = (state_q == fetch_pkg::FETCH) && hit_i && out_free;
    assign refill_we_o = (state_q == fetch_pkg::MISS_WAIT) && refill_valid_i;
    assign redirect_o  = (state_q == fetch_pkg::BRANCH_WAIT) && resolve_valid_i &&
                         resolve_taken_i;
    assign mem_req_o   = (state_q == fetch_pkg::MISS_REQ);
    assign out_valid_o = out_valid_q;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            fetch_pkg::FETCH: begin
                if (!hit_i) begin
                    state_d = fetch_pkg::MISS_REQ;
                end else if (issue_o && is_ctrl_flow) begin
                    state_d = fetch_pkg::BRANCH_WAIT;
                end
            end
            fetch_pkg::MISS_REQ: begin
                if (mem_ready_i) begin
                    state_d = fetch_pkg::MISS_WAIT;
                end
            end
            fetch_pkg::MISS_WAIT: begin
                if (refill_valid_i) begin
                    state_d = fetch_pkg::FETCH;
                end
            end
            fetch_pkg::BRANCH_WAIT: begin
                if (resolve_valid_i) begin
                    state_d = fetch_pkg::FETCH;
                end
            end
            default: state_d = fetch_pkg::FETCH;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q     <= fetch_pkg::FETCH;
            out_valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (issue_o) begin
                out_valid_q <= 1'b1;
            end else if (out_ready_i) begin
                out_valid_q <= 1'b0;
            end
        end
    end

    // Miss request is held until memory takes it
    a_req_held: assert property (@(posedge clk_i) disable iff (reset_i)
        mem_req_o && !mem_ready_i |=> mem_req_o);

endmodule : fetch_fsm

/* design/fetch_pc.sv */
module fetch_pc #(
    parameter int NUM_LINES  = 16,
    parameter int LINE_WORDS = 4
) (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              issue_i,
    input  logic              redirect_i,
    input  fetch_pkg::addr_t  target_i,
    output fetch_pkg::addr_t  fetch_addr_o,
    output fetch_pkg::addr_t  pc_o
);

    localparam int LINE_BYTES = LINE_WORDS * 4;

    fetch_pkg::addr_t fetch_addr_q;
    fetch_pkg::addr_t pc_q;

    // Cache geometry must be power-of-two for the index/offset split
    if (((NUM_LINES & (NUM_LINES - 1)) != 0) ||
        ((LINE_BYTES & (LINE_BYTES - 1)) != 0)) begin : g_bad_geometry
        $error("fetch_pc: NUM_LINES and LINE_WORDS must be powers of two");
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            fetch_addr_q <= '0;
            pc_q         <= '0;
        end else if (redirect_i) begin
            fetch_addr_q <= target_i;
        end else if (issue_i) begin
            fetch_addr_q <= fetch_addr_q + 32'd4;
            pc_q         <= fetch_addr_q;
        end
    end

    assign fetch_addr_o = fetch_addr_q;
    assign pc_o         = pc_q;

    // Redirect only comes out of BRANCH_WAIT, issue only out of FETCH
    a_no_issue_redirect: assert property (@(posedge clk_i) disable iff (reset_i)
        !(issue_i && redirect_i));

    a_word_aligned: assert property (@(posedge clk_i) disable iff (reset_i)
        redirect_i |=> fetch_addr_o[1:0] == 2'b00);

endmodule : fetch_pc

/* design/fetch_pkg.sv */
package fetch_pkg;

    // Byte address and instruction word
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;

    typedef enum logic [1:0] {
        FETCH,
        MISS_REQ,
        MISS_WAIT,
        BRANCH_WAIT
    } fetch_state_e;

    // Major opcodes that stall fetch until resolve
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
    localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
    localparam logic [6:0] OPCODE_JALR   = 7'b1100111;

    // addi x0, x0, 0
    localparam word_t NOP = 32'h0000_0013;

endpackage : fetch_pkg

/* design/fetch_stage.sv */
module fetch_stage #(
    parameter int NUM_LINES  = 16,
    parameter int LINE_WORDS = 4
) (
    input  logic                       clk_i,
    input  logic                       reset_i,

    // Decode
    output logic                       out_valid_o,
    input  logic                       out_ready_i,
    output fetch_pkg::word_t           instr_o,
    output fetch_pkg::addr_t           pc_o,

    // Miss request
    output logic                       mem_req_o,
    input  logic                       mem_ready_i,
    output fetch_pkg::addr_t           mem_addr_o,

    // Refill
    input  logic                       refill_valid_i,
    input  logic [LINE_WORDS*32-1:0]   refill_data_i,

    // Branch resolution from execute
    input  logic                       resolve_valid_i,
    input  logic                       resolve_taken_i,
    input  fetch_pkg::addr_t           resolve_target_i
);

    localparam int OFFSET_W = $clog2(LINE_WORDS) + 2;

    fetch_pkg::addr_t fetch_addr;
    fetch_pkg::word_t rd_word;
    logic             hit;
    logic             issue;
    logic             refill_we;
    logic             redirect;

    // Line address of the current fetch
    assign mem_addr_o = {fetch_addr[31:OFFSET_W], {OFFSET_W{1'b0}}};

    fetch_fsm i_fetch_fsm (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .hit_i           (hit),
        .rd_word_i       (rd_word),
        .out_ready_i     (out_ready_i),
        .mem_ready_i     (mem_ready_i),
        .refill_valid_i  (refill_valid_i),
        .resolve_valid_i (resolve_valid_i),
        .resolve_taken_i (resolve_taken_i),
        .issue_o         (issue),
        .refill_we_o     (refill_we),
        .redirect_o      (redirect),
        .out_valid_o     (out_valid_o),
        .mem_req_o       (mem_req_o)
    );

    fetch_pc #(
        .NUM_LINES  (NUM_LINES),
        .LINE_WORDS (LINE_WORDS)
    ) i_fetch_pc (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .issue_i      (issue),
        .redirect_i   (redirect),
        .target_i     (resolve_target_i),
        .fetch_addr_o (fetch_addr),
        .pc_o         (pc_o)
    );

    icache_tag #(
        .NUM_LINES  (NUM_LINES),
        .LINE_WORDS (LINE_WORDS)
    ) i_icache_tag (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .fetch_addr_i (fetch_addr),
        .refill_we_i  (refill_we),
        .hit_o        (hit)
    );

    icache_data #(
        .NUM_LINES  (NUM_LINES),
        .LINE_WORDS (LINE_WORDS)
    ) i_icache_data (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .fetch_addr_i  (fetch_addr),
        .refill_we_i   (refill_we),
        .issue_i       (issue),
        .refill_data_i (refill_data_i),
        .rd_word_o     (rd_word),
        .instr_o       (instr_o)
    );

endmodule : fetch_stage

/* design/icache_data.sv */
module icache_data #(
    parameter int NUM_LINES  = 16,
    parameter int LINE_WORDS = 4
) (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  fetch_pkg::addr_t           fetch_addr_i,
    input  logic                       refill_we_i,
    input  logic                       issue_i,
    input  logic [LINE_WORDS*32-1:0]   refill_data_i,
    output fetch_pkg::word_t           rd_word_o,
    output fetch_pkg::word_t           instr_o
);

    localparam int WORD_OFF_W = $clog2(LINE_WORDS);
    localparam int OFFSET_W   = WORD_OFF_W + 2;
    localparam int INDEX_W    = $clog2(NUM_LINES);

    typedef logic [LINE_WORDS*32-1:0] line_t;
    typedef logic [INDEX_W-1:0]       index_t;
    typedef logic [WORD_OFF_W-1:0]    word_off_t;

    line_t            lines [NUM_LINES];
    index_t           addr_index;
    word_off_t        word_off;
    line_t            rd_line;
    fetch_pkg::word_t instr_q;

    assign addr_index = fetch_addr_i[OFFSET_W +: INDEX_W];
    assign word_off   = fetch_addr_i[2 +: WORD_OFF_W];

    // Whole line written at once, word 0 in the low bits
    always_ff @(posedge clk_i) begin
        if (refill_we_i) begin
            lines[addr_index] <= refill_data_i;
        end
    end

    assign rd_line   = lines[addr_index];
    assign rd_word_o = rd_line[word_off*32 +: 32];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            instr_q <= fetch_pkg::NOP;
        end else if (issue_i) begin
            instr_q <= rd_word_o;
        end
    end

    assign instr_o = instr_q;

endmodule : icache_data

/* design/icache_tag.sv */
module icache_tag #(
    parameter int NUM_LINES  = 16,
    parameter int LINE_WORDS = 4
) (
    input  logic              clk_i,
    input  logic              reset_i,
    input  fetch_pkg::addr_t  fetch_addr_i,
    input  logic              refill_we_i,
    output logic              hit_o
);

    localparam int OFFSET_W = $clog2(LINE_WORDS) + 2;
    localparam int INDEX_W  = $clog2(NUM_LINES);
    localparam int TAG_W    = 32 - INDEX_W - OFFSET_W;

    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;

    tag_t                 tags [NUM_LINES];
    logic [NUM_LINES-1:0] valid_q;
    tag_t                 addr_tag;
    index_t               addr_index;
    tag_t                 stored_tag;

    // Address split: tag | index | offset
    assign addr_tag   = fetch_addr_i[31 -: TAG_W];
    assign addr_index = fetch_addr_i[OFFSET_W +: INDEX_W];

    assign stored_tag = tags[addr_index];
    assign hit_o      = valid_q[addr_index] && (stored_tag == addr_tag);

    always_ff @(posedge clk_i) begin
        if (refill_we_i) begin
            tags[addr_index] <= addr_tag;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= '0;
        end else if (refill_we_i) begin
            valid_q[addr_index] <= 1'b1;
        end
    end

    // Fetch address is frozen during the miss, so the refilled line hits next
    a_hit_after_refill: assert property (@(posedge clk_i) disable iff (reset_i)
        refill_we_i |=> hit_o);

endmodule : icache_tag

/* verification/tb_fetch_stage.sv */
module tb_fetch_stage;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_LINES     = 16;
    localparam int LINE_WORDS    = 4;
    localparam int OFFSET_W      = $clog2(LINE_WORDS) + 2;
    localparam int INDEX_W       = $clog2(NUM_LINES);
    localparam int CLK_PERIOD    = 100;
    localparam int NUM_TRANSFERS = 3000;

    logic                     clk_i;
    logic                     reset_i;
    logic                     out_valid_o;
    logic                     out_ready_i;
    fetch_pkg::word_t         instr_o;
    fetch_pkg::addr_t         pc_o;
    logic                     mem_req_o;
    logic                     mem_ready_i;
    fetch_pkg::addr_t         mem_addr_o;
    logic                     refill_valid_i;
    logic [LINE_WORDS*32-1:0] refill_data_i;
    logic                     resolve_valid_i;
    logic                     resolve_taken_i;
    fetch_pkg::addr_t         resolve_target_i;

    integer seed = 85462;
    int     errors;
    int     transfers;

    // Memory model keyed by word address
    fetch_pkg::word_t mem_model [fetch_pkg::addr_t];

    // Shadow of the cache contents
    logic             shadow_valid [NUM_LINES];
    fetch_pkg::addr_t shadow_tag [NUM_LINES];

    fetch_pkg::addr_t exp_pc;
    fetch_pkg::addr_t branch_pc;
    fetch_pkg::addr_t refill_addr;
    int               refill_count;
    int               resolve_count;
    logic             wait_resolve;
    logic             seen_req;
    logic             prev_req;
    logic             hold_out;
    fetch_pkg::word_t hold_instr;
    fetch_pkg::addr_t hold_pc;
    logic             hold_req;
    fetch_pkg::addr_t hold_addr;
    logic             expect_next;
    logic             check_reset_state;

    fetch_stage #(
        .NUM_LINES  (NUM_LINES),
        .LINE_WORDS (LINE_WORDS)
    ) i_fetch_stage (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .out_valid_o      (out_valid_o),
        .out_ready_i      (out_ready_i),
        .instr_o          (instr_o),
        .pc_o             (pc_o),
        .mem_req_o        (mem_req_o),
        .mem_ready_i      (mem_ready_i),
        .mem_addr_o       (mem_addr_o),
        .refill_valid_i   (refill_valid_i),
        .refill_data_i    (refill_data_i),
        .resolve_valid_i  (resolve_valid_i),
        .resolve_taken_i  (resolve_taken_i),
        .resolve_target_i (resolve_target_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic report_error(input string msg);
        errors++;
        $display("FAIL at time %0t: %s", $time, msg);
    endtask

    // Random word on first access, about one in eight made a jump or branch
    function automatic fetch_pkg::word_t read_mem_word(input fetch_pkg::addr_t addr);
        fetch_pkg::addr_t key;
        fetch_pkg::word_t w;
        logic [31:0]      pick;
        key = addr >> 2;
        if (!mem_model.exists(key)) begin
            w = $random(seed);
            if ({$random(seed)} % 32'd8 == 32'd0) begin
                pick = {$random(seed)} % 32'd3;
                case (pick)
                    32'd0:   w[6:0] = fetch_pkg::OPCODE_BRANCH;
                    32'd1:   w[6:0] = fetch_pkg::OPCODE_JAL;
                    default: w[6:0] = fetch_pkg::OPCODE_JALR;
                endcase
            end
            mem_model[key] = w;
        end
        return mem_model[key];
    endfunction

    function automatic logic is_ctrl_flow(input fetch_pkg::word_t w);
        case (w[6:0])
            fetch_pkg::OPCODE_BRANCH,
            fetch_pkg::OPCODE_JAL,
            fetch_pkg::OPCODE_JALR: return 1'b1;
            default:                return 1'b0;
        endcase
    endfunction

    function automatic logic line_present(input fetch_pkg::addr_t addr);
        logic [INDEX_W-1:0] idx;
        idx = addr[OFFSET_W +: INDEX_W];
        return shadow_valid[idx] && (shadow_tag[idx] == (addr >> (OFFSET_W + INDEX_W)));
    endfunction

    task automatic mark_line_present(input fetch_pkg::addr_t addr);
        logic [INDEX_W-1:0] idx;
        idx = addr[OFFSET_W +: INDEX_W];
        shadow_valid[idx] = 1'b1;
        shadow_tag[idx]   = addr >> (OFFSET_W + INDEX_W);
    endtask

    // Runs at the rising edge and sees the values from before it
    task automatic check_outputs();
        logic             transfer;
        logic             accept;
        fetch_pkg::word_t exp_instr;
        transfer = out_valid_o && out_ready_i;
        accept   = mem_req_o && mem_ready_i;

        if (check_reset_state) begin
            assert (!out_valid_o && !mem_req_o && instr_o == fetch_pkg::NOP)
            else report_error("outputs not idle after reset");
            check_reset_state = 1'b0;
        end
        if (!seen_req) begin
            assert (!out_valid_o) else report_error("out_valid_o before first miss");
            if (mem_req_o) begin
                assert (mem_addr_o == '0)
                else report_error($sformatf("first mem_addr_o %h", mem_addr_o));
                seen_req = 1'b1;
            end
        end
        if (hold_out) begin
            assert (out_valid_o && instr_o == hold_instr && pc_o == hold_pc)
            else report_error("decode output changed while stalled");
        end
        if (hold_req) begin
            assert (mem_req_o && mem_addr_o == hold_addr)
            else report_error("miss request changed before acceptance");
        end
        if (mem_req_o) begin
            assert (mem_addr_o[OFFSET_W-1:0] == '0)
            else report_error($sformatf("mem_addr_o %h not line aligned", mem_addr_o));
        end
        if (mem_req_o && !prev_req) begin
            assert (!line_present(mem_addr_o))
            else report_error($sformatf("miss request for present line %h", mem_addr_o));
        end
        if (expect_next && out_ready_i) begin
            assert (transfer) else report_error("no transfer one cycle after a hit");
        end
        expect_next = 1'b0;

        if (transfer) begin
            exp_instr = read_mem_word(exp_pc);
            assert (!wait_resolve) else report_error("transfer before branch resolve");
            assert (pc_o == exp_pc)
            else report_error($sformatf("pc_o %h, expected %h", pc_o, exp_pc));
            assert (instr_o == exp_instr)
            else report_error($sformatf("instr_o %h, expected %h", instr_o, exp_instr));
            transfers++;
            if (is_ctrl_flow(exp_instr)) begin
                wait_resolve  = 1'b1;
                branch_pc     = exp_pc;
                resolve_count = 1 + {$random(seed)} % 32'd6;
            end else begin
                // Next word present means it is issued on this same edge
                expect_next = line_present(exp_pc + 4);
                exp_pc      = exp_pc + 4;
            end
        end

        if (resolve_valid_i) begin
            exp_pc       = resolve_taken_i ? resolve_target_i : branch_pc + 4;
            wait_resolve = 1'b0;
        end
        if (refill_valid_i) begin
            mark_line_present(refill_addr);
        end
        if (accept) begin
            refill_addr  = mem_addr_o;
            refill_count = 1 + {$random(seed)} % 32'd8;
        end

        hold_out   = out_valid_o && !out_ready_i;
        hold_instr = instr_o;
        hold_pc    = pc_o;
        hold_req   = mem_req_o && !mem_ready_i;
        hold_addr  = mem_addr_o;
        prev_req   = mem_req_o;
    endtask

    task automatic drive_inputs();
        int w;
        out_ready_i      = ({$random(seed)} % 32'd10) < 32'd7;
        mem_ready_i      = ({$random(seed)} % 32'd2) == 32'd1;
        refill_valid_i   = 1'b0;
        resolve_valid_i  = 1'b0;
        resolve_taken_i  = 1'b0;
        resolve_target_i = '0;

        if (refill_count > 0) begin
            refill_count--;
            if (refill_count == 0) begin
                refill_valid_i = 1'b1;
                for (w = 0; w < LINE_WORDS; w++) begin
                    refill_data_i[w*32 +: 32] = read_mem_word(refill_addr + w * 4);
                end
            end
        end
        if (resolve_count > 0) begin
            resolve_count--;
            if (resolve_count == 0) begin
                resolve_valid_i  = 1'b1;
                resolve_taken_i  = ({$random(seed)} % 32'd2) == 32'd1;
                // Targets stay in a 1 KB window so lines get reused and evicted
                resolve_target_i = ({$random(seed)} % 32'd256) * 32'd4;
            end
        end
    endtask

    initial begin
        reset_i           = 1'b1;
        out_ready_i       = 1'b0;
        mem_ready_i       = 1'b0;
        refill_valid_i    = 1'b0;
        refill_data_i     = '0;
        resolve_valid_i   = 1'b0;
        resolve_taken_i   = 1'b0;
        resolve_target_i  = '0;
        errors            = 0;
        transfers         = 0;
        exp_pc            = '0;
        branch_pc         = '0;
        refill_addr       = '0;
        refill_count      = 0;
        resolve_count     = 0;
        wait_resolve      = 1'b0;
        seen_req          = 1'b0;
        prev_req          = 1'b0;
        hold_out          = 1'b0;
        hold_instr        = '0;
        hold_pc           = '0;
        hold_req          = 1'b0;
        hold_addr         = '0;
        expect_next       = 1'b0;
        check_reset_state = 1'b0;
        for (int i = 0; i < NUM_LINES; i++) begin
            shadow_valid[i] = 1'b0;
            shadow_tag[i]   = '0;
        end

        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        reset_i           = 1'b0;
        check_reset_state = 1'b1;

        while (transfers < NUM_TRANSFERS) begin
            @(posedge clk_i);
            check_outputs();
            @(negedge clk_i);
            drive_inputs();
        end

        $display("Transfers: %0d, errors: %0d", transfers, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(NUM_TRANSFERS * 40 * CLK_PERIOD);
        $display("Simulation timed out after %0d of %0d transfers", transfers, NUM_TRANSFERS);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule : tb_fetch_stage

/* verilog.f */
design/fetch_pkg.sv
design/fetch_fsm.sv
design/fetch_pc.sv
design/icache_tag.sv
design/icache_data.sv
design/fetch_stage.sv
verification/tb_fetch_stage.sv
